//--- src/mixer_macros.svh
/*
 * Widths shared by the audio mixer packages, RTL and testbench.
 * SUM_W must stay one bit wider than AUD_W so a sample plus the second
 * source cannot wrap. ATT_W holds a mute flag on top of a 4-bit shift.
 */
`ifndef MIXER_MACROS_SVH
`define MIXER_MACROS_SVH

// Audio sample and internal sum
`define AUD_W 16
`define SUM_W 17

// Attenuation, top bit mutes, low bits are the right shift
`define ATT_W 5

// Host command port
`define HOST_W 16
`define OPC_W 8

`endif

//--- src/audio_pkg.sv
/*
 * Audio data types for the stereo mixing pipeline.
 * Both channels travel together so a stage always sees left and right
 * samples from the same pipeline slot.
 */
`include "mixer_macros.svh"

package audio_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Samples and sums
	////////////////////////////////////////////////////////////////////////////

	// Raw sample, signedness set by the source
	typedef logic [`AUD_W-1:0] sample_t;

	// Internal sum, always two's complement
	typedef logic signed [`SUM_W-1:0] sum_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_sample_t;

	typedef struct packed {
		sum_t left;
		sum_t right;
	} stereo_sum_t;

	////////////////////////////////////////////////////////////////////////////
	// Crossfeed modes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MIX_NONE   = 2'd0,
		MIX_LIGHT  = 2'd1,	// 1/8 of the other channel
		MIX_MEDIUM = 2'd2,	// 1/4 of the other channel
		MIX_MONO   = 2'd3	// Half and half
	} mix_mode_e;

endpackage

//--- src/host_pkg.sv
/*
 * Host command port types.
 * The first strobe of a select window carries the opcode, every later
 * strobe a data word for it. Unknown opcodes are accepted and ignored.
 */
`include "mixer_macros.svh"

package host_pkg;

	// One word as written by the host
	typedef logic [`HOST_W-1:0] host_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	// Only the volume opcode writes anything here
	typedef enum logic [`OPC_W-1:0] {
		OPC_NONE   = `OPC_W'h00,
		OPC_VOLUME = `OPC_W'h26
	} opcode_e;

	////////////////////////////////////////////////////////////////////////////
	// Decoder state
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic {
		DEC_WAIT_CMD = 1'b0,
		DEC_HAVE_CMD = 1'b1
	} dec_state_e;

endpackage

//--- src/host_cmd_decoder.sv
/*
 * Host command decoder. i_io_sel, i_io_clk and i_io_din are registered
 * once before use, so i_io_din must be stable while i_io_clk is high.
 * o_att changes one cycle after a rising i_io_clk is sampled.
 * No handshake back to the host.
 */
`include "mixer_macros.svh"

module host_cmd_decoder (
	input  logic                 clk,
	input  logic                 resetd,
	input  logic                 i_io_sel,
	input  logic                 i_io_clk,
	input  host_pkg::host_word_t i_io_din,
	output logic [`ATT_W-1:0]    o_att
);

	import host_pkg::*;

	logic       sel_q;
	logic       io_clk_q;
	logic       io_clk_qq;
	host_word_t din_q;
	logic       strobe;
	opcode_e    opcode;
	dec_state_e state;

	// Input capture and strobe edge
	always_ff @(posedge clk) begin
		if (resetd) begin
			sel_q     <= 1'b0;
			io_clk_q  <= 1'b0;
			io_clk_qq <= 1'b0;
		end else begin
			sel_q     <= i_io_sel;
			io_clk_q  <= i_io_clk;
			io_clk_qq <= io_clk_q;
		end
	end

	// Data word lines up with io_clk_q
	always_ff @(posedge clk) begin
		din_q <= i_io_din;
	end

	assign strobe = io_clk_q & ~io_clk_qq;

	////////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state  <= DEC_WAIT_CMD;
			opcode <= OPC_NONE;
			o_att  <= '0;
		end else if (!sel_q) begin
			state <= DEC_WAIT_CMD;
		end else if (strobe) begin
			if (state == DEC_WAIT_CMD) begin
				opcode <= opcode_e'(din_q[`OPC_W-1:0]);
				state  <= DEC_HAVE_CMD;
			end else if (opcode == OPC_VOLUME) begin
				o_att <= din_q[`ATT_W-1:0];
			end
		end
	end

endmodule

//--- src/sample_stabilizer.sv
/*
 * Deglitcher for core audio coming from another clock domain.
 * A pair must be held for two cycles to pass; it shows up on the fourth
 * edge after it is first sampled. Fast toggling keeps the last value.
 */
`include "mixer_macros.svh"

module sample_stabilizer (
	input  logic                     clk,
	input  logic                     resetd,
	input  audio_pkg::stereo_sample_t i_core,
	output audio_pkg::stereo_sample_t o_core
);

	import audio_pkg::*;

	// Sample history, d1 is the newest
	stereo_sample_t d1;
	stereo_sample_t d2;
	stereo_sample_t d3;

	always_ff @(posedge clk) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
		end
	end

	// Pass on only when the two oldest entries agree
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_core <= '0;
		end else if (d2 == d3) begin
			o_core <= d2;
		end
	end

endmodule

//--- src/mix_sum_stage.sv
/*
 * Converts the core pair to signed sums and adds the second source.
 * Unsigned core samples are halved to fit the signed range.
 * The second source is always signed and is registered in the first
 * cycle, then added in the second.
 */
`include "mixer_macros.svh"

module mix_sum_stage (
	input  logic                      clk,
	input  logic                      resetd,
	input  audio_pkg::stereo_sample_t i_core,
	input  audio_pkg::stereo_sample_t i_second,
	input  logic                      i_is_signed,
	output audio_pkg::stereo_sum_t    o_sum
);

	import audio_pkg::*;

	stereo_sum_t    core_q;
	stereo_sample_t second_q;

	// Core sample into the signed sum domain
	function automatic sum_t to_sum(sample_t s, logic is_signed);
		if (is_signed)
			return {s[`AUD_W-1], s};
		return {2'b00, s[`AUD_W-1:1]};
	endfunction

	function automatic sum_t sext(sample_t s);
		return {s[`AUD_W-1], s};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, conversion
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_q   <= '0;
			second_q <= '0;
		end else begin
			core_q.left  <= to_sum(i_core.left, i_is_signed);
			core_q.right <= to_sum(i_core.right, i_is_signed);
			second_q     <= i_second;
		end
	end

	// Stage 2, second source joins
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sum <= '0;
		end else begin
			o_sum.left  <= core_q.left + sext(second_q.left);
			o_sum.right <= core_q.right + sext(second_q.right);
		end
	end

endmodule

//--- src/crossfeed_stage.sv
/*
 * Crossfeed between left and right. Each channel takes the other
 * channel's halved sum from the same pipeline slot. All divisions are
 * arithmetic shifts, so results round toward minus infinity.
 * i_mix is expected to be static while audio plays.
 */
`include "mixer_macros.svh"

module crossfeed_stage (
	input  logic                   clk,
	input  logic                   resetd,
	input  audio_pkg::stereo_sum_t i_sum,
	input  audio_pkg::mix_mode_e   i_mix,
	output audio_pkg::stereo_sum_t o_sum
);

	import audio_pkg::*;

	// Blend of one channel with the other one
	function automatic sum_t blend(sum_t own, sum_t other_sum, mix_mode_e mode);
		sum_t other;
		sum_t res;
		other = other_sum >>> 1;
		case (mode)
			MIX_NONE:   res = own;
			MIX_LIGHT:  res = own - (own >>> 3) + (other >>> 2);
			MIX_MEDIUM: res = own - (own >>> 2) + (other >>> 1);
			MIX_MONO:   res = (own >>> 1) + other;
			default:    res = own;
		endcase
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sum <= '0;
		end else begin
			o_sum.left  <= blend(i_sum.left, i_sum.right, i_mix);
			o_sum.right <= blend(i_sum.right, i_sum.left, i_mix);
		end
	end

endmodule

//--- src/gain_clamp_stage.sv
/*
 * Volume attenuation and saturation to 16 bits.
 * Top bit of i_att mutes, the low bits give a right shift of 0 to 15.
 * One cycle for the shift and one for the clamp.
 */
`include "mixer_macros.svh"

module gain_clamp_stage (
	input  logic                      clk,
	input  logic                      resetd,
	input  audio_pkg::stereo_sum_t    i_sum,
	input  logic [`ATT_W-1:0]         i_att,
	output audio_pkg::stereo_sample_t o_out
);

	import audio_pkg::*;

	stereo_sum_t shifted;

	// Saturate a sum to the sample range
	function automatic sample_t sat(sum_t v);
		if (v[`SUM_W-1] != v[`AUD_W-1])
			return {v[`SUM_W-1], {(`AUD_W-1){v[`AUD_W-1]}}};
		return v[`AUD_W-1:0];
	endfunction

	// Attenuation
	always_ff @(posedge clk) begin
		if (resetd || i_att[`ATT_W-1]) begin
			shifted <= '0;
		end else begin
			shifted.left  <= i_sum.left >>> i_att[`ATT_W-2:0];
			shifted.right <= i_sum.right >>> i_att[`ATT_W-2:0];
		end
	end

	// Clamp to 0x7FFF or 0x8000
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_out <= '0;
		end else begin
			o_out.left  <= sat(shifted.left);
			o_out.right <= sat(shifted.right);
		end
	end

endmodule

//--- src/audio_mixer_top.sv
/*
 * Stereo audio mixer with host volume control.
 * Core latency is 9 edges for a sample held 2 cycles or more, the
 * second source 5 edges. i_is_signed and i_mix are static levels.
 */
`include "mixer_macros.svh"

module audio_mixer_top (
	input  logic                      clk,
	input  logic                      resetd,
	input  logic                      i_io_sel,
	input  logic                      i_io_clk,
	input  host_pkg::host_word_t      i_io_din,
	input  audio_pkg::stereo_sample_t i_core,
	input  audio_pkg::stereo_sample_t i_second,
	input  logic                      i_is_signed,
	input  audio_pkg::mix_mode_e      i_mix,
	output audio_pkg::stereo_sample_t o_out
);

	import audio_pkg::*;

	logic [`ATT_W-1:0] att;
	stereo_sample_t    core_stable;
	stereo_sum_t       mixed;
	stereo_sum_t       crossed;

	////////////////////////////////////////////////////////////////////////////
	// Host control
	////////////////////////////////////////////////////////////////////////////

	host_cmd_decoder u_dec (
		.clk      (clk),
		.resetd   (resetd),
		.i_io_sel (i_io_sel),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_att    (att)
	);

	////////////////////////////////////////////////////////////////////////////
	// Audio pipeline
	////////////////////////////////////////////////////////////////////////////

	sample_stabilizer u_stab (
		.clk    (clk),
		.resetd (resetd),
		.i_core (i_core),
		.o_core (core_stable)
	);

	mix_sum_stage u_sum (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (core_stable),
		.i_second    (i_second),
		.i_is_signed (i_is_signed),
		.o_sum       (mixed)
	);

	crossfeed_stage u_xfeed (
		.clk    (clk),
		.resetd (resetd),
		.i_sum  (mixed),
		.i_mix  (i_mix),
		.o_sum  (crossed)
	);

	gain_clamp_stage u_gain (
		.clk    (clk),
		.resetd (resetd),
		.i_sum  (crossed),
		.i_att  (att),
		.o_out  (o_out)
	);

endmodule

//--- tb/audio_mixer_sva.sv
/*
 * Concurrent checks on the mixer top level, attached by bind.
 * The stability check counts cycles with all pipeline inputs unchanged,
 * including the volume setting, and restarts after reset.
 */
`include "mixer_macros.svh"

module audio_mixer_sva (
	input  logic                      clk,
	input  logic                      resetd,
	input  audio_pkg::stereo_sample_t i_core,
	input  audio_pkg::stereo_sample_t i_second,
	input  logic                      i_is_signed,
	input  audio_pkg::mix_mode_e      i_mix,
	input  logic [`ATT_W-1:0]         i_att,
	input  audio_pkg::stereo_sample_t o_out
);

	logic [4*`AUD_W+3+`ATT_W-1:0] in_now;
	logic [4*`AUD_W+3+`ATT_W-1:0] in_prev;
	logic                         rst_q;
	logic [3:0]                   steady_cnt;

	assign in_now = {i_core, i_second, i_is_signed, i_mix, i_att};

	// Cycles since the last input change
	always_ff @(posedge clk) begin
		rst_q   <= resetd;
		in_prev <= in_now;
		if (resetd || rst_q || in_now != in_prev)
			steady_cnt <= '0;
		else if (steady_cnt != 4'hF)
			steady_cnt <= steady_cnt + 4'd1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////////////////////

	a_reset_clears: assert property (@(posedge clk) resetd |=> (o_out == '0))
		else $error("o_out not zero during reset");

	a_mute: assert property (@(posedge clk) disable iff (resetd)
		(i_att[`ATT_W-1] && $past(i_att[`ATT_W-1]) && $past(i_att[`ATT_W-1], 2))
		|-> (o_out == '0))
		else $error("o_out not zero three cycles into mute");

	a_settled: assert property (@(posedge clk) disable iff (resetd)
		(steady_cnt >= 4'd9) |-> $stable(o_out))
		else $error("o_out moved after nine cycles of steady inputs");

endmodule

bind audio_mixer_top audio_mixer_sva u_sva (
	.clk         (clk),
	.resetd      (resetd),
	.i_core      (i_core),
	.i_second    (i_second),
	.i_is_signed (i_is_signed),
	.i_mix       (i_mix),
	.i_att       (att),
	.o_out       (o_out)
);

//--- tb/audio_mixer_tb.sv
/*
 * Testbench for the stereo audio mixer. Every case holds its inputs for
 * 16 cycles before o_out is compared with mix_ref. The expected volume
 * tracks the OPC_VOLUME words that the host task sends.
 */
`include "mixer_macros.svh"

module audio_mixer_tb;

	import audio_pkg::*;
	import host_pkg::*;

	localparam int HOLD_CYCLES   = 16;
	localparam int CHECK_TIMEOUT = 50;
	localparam int SAT_MAX       = (1 << (`AUD_W - 1)) - 1;
	localparam int SAT_MIN       = -(1 << (`AUD_W - 1));

	logic           clk;
	logic           resetd;
	logic           io_sel;
	logic           io_clk;
	host_word_t     io_din;
	stereo_sample_t core;
	stereo_sample_t second;
	logic           is_signed;
	mix_mode_e      mix;
	stereo_sample_t out_sample;

	// Shared between stimulus and the comparing process
	logic [`ATT_W-1:0] att_model;
	stereo_sample_t    exp_out;
	string             case_name;
	logic              watch;
	int                req_count = 0;
	int                done_count = 0;
	int                n_checks = 0;
	int                n_errors = 0;
	int                n_timeouts = 0;

	audio_mixer_top dut0 (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_sel    (io_sel),
		.i_io_clk    (io_clk),
		.i_io_din    (io_din),
		.i_core      (core),
		.i_second    (second),
		.i_is_signed (is_signed),
		.i_mix       (mix),
		.o_out       (out_sample)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Unsigned core samples lose their LSB to fit the signed range
	function automatic int core_value(sample_t v, logic sgn);
		if (sgn)
			return int'($signed(v));
		return int'(v) / 2;
	endfunction

	function automatic int crossfeed(int own, int other_sum, mix_mode_e m);
		int half;
		int res;
		half = other_sum >>> 1;
		case (m)
			MIX_LIGHT:  res = own - (own >>> 3) + (half >>> 2);
			MIX_MEDIUM: res = own - (own >>> 2) + (half >>> 1);
			MIX_MONO:   res = (own >>> 1) + half;
			default:    res = own;
		endcase
		return res;
	endfunction

	function automatic sample_t attenuate(int v, logic [`ATT_W-1:0] a);
		int r;
		if (a[`ATT_W-1])
			r = 0;
		else
			r = v >>> a[`ATT_W-2:0];
		if (r > SAT_MAX)
			r = SAT_MAX;
		else if (r < SAT_MIN)
			r = SAT_MIN;
		return sample_t'(r);
	endfunction

	function automatic stereo_sample_t mix_ref(stereo_sample_t c, stereo_sample_t s,
			logic sgn, mix_mode_e m, logic [`ATT_W-1:0] a);
		int sum_l;
		int sum_r;
		stereo_sample_t r;
		sum_l   = core_value(c.left, sgn) + int'($signed(s.left));
		sum_r   = core_value(c.right, sgn) + int'($signed(s.right));
		r.left  = attenuate(crossfeed(sum_l, sum_r, m), a);
		r.right = attenuate(crossfeed(sum_r, sum_l, m), a);
		return r;
	endfunction

	// Compares on the falling edge where o_out is settled
	initial begin : compare
		forever begin
			@(negedge clk);
			if (watch || done_count != req_count) begin
				n_checks++;
				assert (out_sample == exp_out) else begin
					n_errors++;
					$display("FAIL %0t: %s, expected %h, got %h",
						$time, case_name, exp_out, out_sample);
				end
				done_count = req_count;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cycles(int n);
		repeat (n) next_cycle();
	endtask

	function automatic stereo_sample_t pair(sample_t l, sample_t r);
		stereo_sample_t p;
		p.left  = l;
		p.right = r;
		return p;
	endfunction

	function automatic stereo_sample_t rand_pair();
		return pair(sample_t'($urandom), sample_t'($urandom));
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// One host strobe with two cycles per level
	task automatic host_strobe(host_word_t data);
		io_din = data;
		io_clk = 1'b1;
		wait_cycles(2);
		io_clk = 1'b0;
		wait_cycles(2);
	endtask

	task automatic host_write(logic [`OPC_W-1:0] opc, host_word_t data);
		io_sel = 1'b1;
		wait_cycles(2);
		host_strobe(host_word_t'(opc));
		host_strobe(data);
		io_sel = 1'b0;
		wait_cycles(2);
		if (opc == OPC_VOLUME)
			att_model = data[`ATT_W-1:0];
	endtask

	task automatic request_check(string name);
		int waited;
		waited    = 0;
		case_name = name;
		exp_out   = mix_ref(core, second, is_signed, mix, att_model);
		req_count++;
		while (done_count != req_count && waited < CHECK_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (done_count != req_count) begin
			n_timeouts++;
			$display("Timeout: the comparing process never took the check for %s", name);
			finish_run();
		end else begin
			#1;
		end
	endtask

	task automatic apply_case(string name, stereo_sample_t c, stereo_sample_t s,
			logic sgn, mix_mode_e m);
		core      = c;
		second    = s;
		is_signed = sgn;
		mix       = m;
		wait_cycles(HOLD_CYCLES);
		request_check(name);
	endtask

	// One glitch cycle inside a held value and a check on every cycle
	task automatic glitch_window(stereo_sample_t glitch);
		stereo_sample_t held;
		held      = core;
		case_name = "glitch window";
		exp_out   = mix_ref(core, second, is_signed, mix, att_model);
		watch     = 1'b1;
		core      = glitch;
		next_cycle();
		core = held;
		wait_cycles(HOLD_CYCLES);
		watch = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		mix_mode_e      modes[4];
		stereo_sample_t base;
		modes = '{MIX_NONE, MIX_LIGHT, MIX_MEDIUM, MIX_MONO};
		void'($urandom(70));
		resetd    = 1'b1;
		io_sel    = 1'b0;
		io_clk    = 1'b0;
		io_din    = '0;
		core      = '0;
		second    = '0;
		is_signed = 1'b1;
		mix       = MIX_NONE;
		att_model = '0;
		exp_out   = '0;
		watch     = 1'b0;
		case_name = "";
		repeat (4) @(posedge clk);
		#1;
		resetd = 1'b0;

		// Full volume straight through
		for (int i = 0; i < 4; i++)
			apply_case("signed none", rand_pair(), rand_pair(), 1'b1, MIX_NONE);
		for (int i = 0; i < 3; i++)
			apply_case("unsigned core", rand_pair(), rand_pair(), 1'b0, MIX_NONE);

		foreach (modes[i]) begin
			apply_case("crossfeed", rand_pair(), rand_pair(), 1'b1, modes[i]);
			apply_case("crossfeed", rand_pair(), rand_pair(), 1'b1, modes[i]);
		end
		apply_case("mono wide", pair(16'h6000, 16'hA000), pair(16'h1000, 16'h0800),
			1'b1, MIX_MONO);

		// Volume writes and a foreign opcode that must not unmute
		host_write(OPC_VOLUME, 16'h0000);
		apply_case("shift 0", rand_pair(), rand_pair(), 1'b1, MIX_LIGHT);
		host_write(OPC_VOLUME, 16'h0003);
		apply_case("shift 3", rand_pair(), rand_pair(), 1'b1, MIX_NONE);
		host_write(OPC_VOLUME, 16'h000F);
		apply_case("shift 15", rand_pair(), rand_pair(), 1'b1, MIX_MEDIUM);
		host_write(OPC_VOLUME, 16'h0010);
		apply_case("mute", rand_pair(), rand_pair(), 1'b1, MIX_NONE);
		host_write(8'h13, 16'h0000);
		apply_case("other opcode", rand_pair(), rand_pair(), 1'b1, MIX_NONE);
		host_write(OPC_VOLUME, 16'h0000);

		// Saturation at both ends
		apply_case("saturate", pair(16'h7FF0, 16'h8010), pair(16'h7F00, 16'h8100),
			1'b1, MIX_NONE);
		apply_case("saturate high", pair(16'h7FFF, 16'h7FFF), pair(16'h7FFF, 16'h7FFF),
			1'b1, MIX_LIGHT);
		apply_case("saturate low", pair(16'h8000, 16'h8000), pair(16'h8000, 16'h8000),
			1'b1, MIX_LIGHT);
		apply_case("saturate unsigned", pair(16'hFFFF, 16'hFFFF), pair(16'h7FFF, 16'h7FFF),
			1'b0, MIX_NONE);

		base = rand_pair();
		apply_case("glitch hold", base, pair(16'h0100, 16'hFF00), 1'b1, MIX_MEDIUM);
		glitch_window(stereo_sample_t'(~base));

		finish_run();
	end

endmodule

//--- list.f
+incdir+src
src/audio_pkg.sv
src/host_pkg.sv
src/host_cmd_decoder.sv
src/sample_stabilizer.sv
src/mix_sum_stage.sv
src/crossfeed_stage.sv
src/gain_clamp_stage.sv
src/audio_mixer_top.sv
tb/audio_mixer_sva.sv
tb/audio_mixer_tb.sv

//--- Makefile
# Verilator build and run of the audio mixer testbench

VERILATOR ?= verilator
TOP       ?= audio_mixer_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
